// File: dv/lwe_mem_tb.sv
`timescale 1ns/1ns

module lwe_mem_tb
   import lwe_mem_pkg::*;
();

   localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
   // two phases of 4 * TOTAL_WORDS frames plus a few extra and some margin
   localparam int TIMEOUT_CYCLES = 3 * (4 * TOTAL_WORDS + 8) * FRAME_CYCLES;

   logic clk_100mhz;
   logic sys_rst;
   logic uart_rxd;
   logic load_mode;
   logic dump_en;
   logic uart_txd;
   logic dump_done;
   logic [INDEX_BITS-1:0] word_count;

   logic [WORD_BITS-1:0] words [TOTAL_WORDS];
   logic [31:0] lfsr_state = 32'ha60f2bb1;
   logic [7:0] dump_q [$]; // bytes decoded from uart_txd
   logic [7:0] tx_data;
   logic dump_done_q = 1'b0;
   int bit_i;
   int start_count = 0;
   int starts_at_done;
   int cycle_count = 0;
   int value_errors = 0;
   int other_errors = 0;

   lwe_mem_top uut (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .uart_rxd(uart_rxd),
      .load_mode(load_mode),
      .dump_en(dump_en),
      .uart_txd(uart_txd),
      .dump_done(dump_done),
      .word_count(word_count)
   );

   always #5 clk_100mhz = ~clk_100mhz;

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // narrow regions come back as the low bits in every byte
   function automatic logic [7:0] expected_byte(input int idx, input int pos);
      if (idx >= PT_BASE && idx < B_BASE) begin
         return 8'(words[idx][NARROW_BITS-1:0]);
      end
      return words[idx][8*pos +: 8];
   endfunction

   task automatic make_words();
      int w;
      int k;
      for (w = 0; w < TOTAL_WORDS; w++) begin
         for (k = 0; k < WORD_BITS; k++) begin
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
            words[w][k] = lfsr_state[0];
         end
      end
   endtask

   task automatic send_frame(input logic [7:0] data);
      logic [9:0] bits;
      int b;
      bits = {1'b1, data, 1'b0}; // stop, data lsb first, start
      for (b = 0; b < 10; b++) begin
         @(posedge clk_100mhz);
         uart_rxd <= bits[b];
         repeat (CLKS_PER_BIT - 1) @(posedge clk_100mhz);
      end
   endtask

   task automatic check_count(input int expected);
      assert (word_count == INDEX_BITS'(expected)) else begin
         $display("Error at time %0t: word_count expected %0d actual %0d",
                  $time, expected, word_count);
         value_errors++;
      end
   endtask

   task automatic compare_dump();
      logic [7:0] exp_byte;
      int idx;
      for (idx = 0; idx < dump_q.size() && idx < 4 * TOTAL_WORDS; idx++) begin
         exp_byte = expected_byte(idx / 4, idx % 4);
         assert (dump_q[idx] == exp_byte) else begin
            $display("Error at time %0t: uart_txd byte %0d expected 8'h%02h actual 8'h%02h",
                     $time, idx, exp_byte, dump_q[idx]);
            value_errors++;
         end
      end
   endtask

   always @(posedge clk_100mhz) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the dump never finished", cycle_count);
         $display("Verification failed");
         $finish;
      end
   end

   always @(negedge clk_100mhz) begin
      dump_done_q <= dump_done;
      if (!sys_rst) begin
         assert (word_count <= INDEX_BITS'(TOTAL_WORDS)) else begin
            $display("Error at time %0t: word_count expected <= %0d actual %0d",
                     $time, TOTAL_WORDS, word_count);
            value_errors++;
         end
         if (dump_done && !dump_done_q) begin
            assert (dump_q.size() == 4 * TOTAL_WORDS) else begin
               $display("dump_done rose after %0d bytes instead of %0d",
                        dump_q.size(), 4 * TOTAL_WORDS);
               other_errors++;
            end
         end
      end
   end

   // serial receiver on uart_txd sampling mid bit
   initial begin
      @(negedge sys_rst);
      forever begin
         @(negedge clk_100mhz);
         if (!uart_txd) begin
            start_count++;
            repeat (CLKS_PER_BIT / 2) @(negedge clk_100mhz);
            assert (!uart_txd) else begin
               $display("start bit on uart_txd ended early at %0t", $time);
               other_errors++;
            end
            for (bit_i = 0; bit_i < 8; bit_i++) begin
               repeat (CLKS_PER_BIT) @(negedge clk_100mhz);
               tx_data[bit_i] = uart_txd;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_100mhz);
            assert (uart_txd) else begin
               $display("stop bit on uart_txd was low at %0t", $time);
               other_errors++;
            end
            dump_q.push_back(tx_data);
         end
      end
   end

   initial begin
      clk_100mhz = 1'b0;
      sys_rst = 1'b1;
      uart_rxd = 1'b1;
      load_mode = 1'b0;
      dump_en = 1'b0;
      make_words();
      repeat (8) @(posedge clk_100mhz);
      sys_rst <= 1'b0;
      @(negedge clk_100mhz);
      assert (uart_txd) else begin
         $display("Error at time %0t: uart_txd expected 1 actual %b", $time, uart_txd);
         value_errors++;
      end
      assert (!dump_done) else begin
         $display("Error at time %0t: dump_done expected 0 actual %b", $time, dump_done);
         value_errors++;
      end
      check_count(0);

      // a whole word sent with load_mode low must not be stored
      for (int i = 0; i < 4; i++) begin
         send_frame(8'(8'h5a ^ i));
      end
      repeat (2 * CLKS_PER_BIT) @(negedge clk_100mhz);
      check_count(0);

      @(posedge clk_100mhz);
      load_mode <= 1'b1;
      for (int w = 0; w < TOTAL_WORDS; w++) begin
         for (int p = 0; p < 4; p++) begin
            send_frame(words[w][8*p +: 8]);
         end
      end
      repeat (2 * CLKS_PER_BIT) @(negedge clk_100mhz);
      check_count(TOTAL_WORDS);

      // one word too many must leave the count alone
      for (int i = 0; i < 4; i++) begin
         send_frame(8'(8'hc3 ^ i));
      end
      repeat (2 * CLKS_PER_BIT) @(negedge clk_100mhz);
      check_count(TOTAL_WORDS);

      @(posedge clk_100mhz);
      load_mode <= 1'b0;
      dump_en <= 1'b1;
      while (!dump_done) @(negedge clk_100mhz);
      compare_dump();

      starts_at_done = start_count;
      repeat (3 * FRAME_CYCLES) @(negedge clk_100mhz);
      assert (start_count == starts_at_done) else begin
         $display("uart_txd sent another frame after dump_done");
         other_errors++;
      end

      @(posedge clk_100mhz);
      dump_en <= 1'b0;
      repeat (2) @(negedge clk_100mhz);
      assert (!dump_done) else begin
         $display("Error at time %0t: dump_done expected 0 actual %b", $time, dump_done);
         value_errors++;
      end

      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: lwe_mem_top.f
verilog/lwe_mem_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/byte_packer.sv
verilog/region_memory.sv
verilog/dump_sequencer.sv
verilog/lwe_mem_top.sv
dv/lwe_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the result
verilator --binary --timing --assert --top-module lwe_mem_tb \
   -f lwe_mem_top.f -o lwe_mem_sim || exit 1
./obj_dir/lwe_mem_sim | tee sim.log
grep -q "^Verification passed" sim.log && echo "run_sim: simulation passed" || {
   echo "run_sim: simulation failed"
   exit 1
}

// File: verilog/byte_packer.sv
`timescale 1ns/1ns
`default_nettype none

module byte_packer
   import lwe_mem_pkg::*;
(
   input wire clk_100mhz,
   input wire sys_rst,
   input wire load_mode,
   input wire rx_valid,
   input wire [7:0] rx_byte,
   output logic word_valid,
   output logic [WORD_BITS-1:0] word
);

   logic [1:0] byte_pos;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         byte_pos <= '0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= load_mode && rx_valid && byte_pos == 2'd3;
         if (!load_mode) begin
            byte_pos <= '0; // realign on every new load
         end else if (rx_valid) begin
            byte_pos <= byte_pos + 1'b1;
         end
      end
   end

   // little endian, after four bytes the first one sits in 7:0
   always_ff @(posedge clk_100mhz) begin
      if (rx_valid) begin
         word <= {rx_byte, word[WORD_BITS-1:8]};
      end
   end

endmodule

`default_nettype wire

// File: verilog/dump_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module dump_sequencer
   import lwe_mem_pkg::*;
(
   input wire clk_100mhz,
   input wire sys_rst,
   input wire dump_en,
   input wire busy,
   input wire [WORD_BITS-1:0] rd_data,
   output logic [INDEX_BITS-1:0] rd_index,
   output logic tx_start,
   output logic [7:0] tx_byte,
   output logic dump_done
);

   logic [1:0] state;
   logic [1:0] byte_pos;
   logic settle_cnt; // two cycle wait for rd_data
   logic issue;

   // tx_start still high means busy has not risen yet
   assign issue = dump_en && state == SEQ_SEND && !busy && !tx_start;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst || !dump_en) begin
         state <= SEQ_SETTLE;
         settle_cnt <= 1'b0;
         rd_index <= '0;
         byte_pos <= '0;
         tx_start <= 1'b0;
         dump_done <= 1'b0;
      end else begin
         tx_start <= issue;
         case (state)
            SEQ_SETTLE: begin
               settle_cnt <= !settle_cnt;
               if (settle_cnt) begin
                  state <= SEQ_SEND;
               end
            end
            SEQ_SEND: begin
               if (issue) begin
                  byte_pos <= byte_pos + 1'b1;
                  if (byte_pos == 2'd3) begin
                     state <= SEQ_ADVANCE;
                  end
               end
            end
            SEQ_ADVANCE: begin
               if (rd_index == INDEX_BITS'(TOTAL_WORDS - 1)) begin
                  state <= SEQ_DONE;
               end else begin
                  rd_index <= rd_index + 1'b1;
                  state <= SEQ_SETTLE;
               end
            end
            SEQ_DONE: begin
               // hold off until the last frame has left the line
               if (!busy && !tx_start) begin
                  dump_done <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (issue) begin
         tx_byte <= rd_data[{byte_pos, 3'b000} +: 8]; // low byte first
      end
   end

endmodule

`default_nettype wire

// File: verilog/lwe_mem_pkg.sv
package lwe_mem_pkg;

   // region depths, shrunk for simulation
   localparam int A_DEPTH = 64;
   localparam int PT_DEPTH = 16;
   localparam int SK_DEPTH = 16;
   localparam int B_DEPTH = 32;
   localparam int TOTAL_WORDS = A_DEPTH + PT_DEPTH + SK_DEPTH + B_DEPTH;

   localparam int WORD_BITS = 32;
   localparam int NARROW_BITS = 2; // pt and sk entries

   // first global word index of each region, A starts at 0
   localparam int PT_BASE = A_DEPTH;
   localparam int SK_BASE = PT_BASE + PT_DEPTH;
   localparam int B_BASE = SK_BASE + SK_DEPTH;

   localparam int INDEX_BITS = $clog2(TOTAL_WORDS + 1); // count reaches TOTAL_WORDS
   localparam int A_ADDR_BITS = $clog2(A_DEPTH);
   localparam int PT_ADDR_BITS = $clog2(PT_DEPTH);
   localparam int SK_ADDR_BITS = $clog2(SK_DEPTH);
   localparam int B_ADDR_BITS = $clog2(B_DEPTH);

   // uart bit period in clk_100mhz cycles
   localparam int CLKS_PER_BIT = 16;
   localparam int BAUD_CNT_BITS = $clog2(CLKS_PER_BIT);

   // region codes
   localparam logic [1:0] REGION_A = 2'd0;
   localparam logic [1:0] REGION_PT = 2'd1;
   localparam logic [1:0] REGION_SK = 2'd2;
   localparam logic [1:0] REGION_B = 2'd3;

   // dump sequencer states
   localparam logic [1:0] SEQ_SETTLE = 2'd0;
   localparam logic [1:0] SEQ_SEND = 2'd1;
   localparam logic [1:0] SEQ_ADVANCE = 2'd2;
   localparam logic [1:0] SEQ_DONE = 2'd3;

endpackage

// File: verilog/lwe_mem_top.sv
`timescale 1ns/1ns
`default_nettype none

module lwe_mem_top
   import lwe_mem_pkg::*;
(
   input wire clk_100mhz,
   input wire sys_rst,
   input wire uart_rxd,
   input wire load_mode,
   input wire dump_en,
   output logic uart_txd,
   output logic dump_done,
   output logic [INDEX_BITS-1:0] word_count
);

   // receive side
   logic rx_valid;
   logic [7:0] rx_byte;
   logic word_valid;
   logic [WORD_BITS-1:0] word;

   // dump side
   logic [INDEX_BITS-1:0] rd_index;
   logic [WORD_BITS-1:0] rd_data;
   logic tx_start;
   logic [7:0] tx_byte;
   logic tx_busy;

   uart_rx u_uart_rx (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .rxd(uart_rxd),
      .rx_valid(rx_valid),
      .rx_byte(rx_byte)
   );

   byte_packer u_byte_packer (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .load_mode(load_mode),
      .rx_valid(rx_valid),
      .rx_byte(rx_byte),
      .word_valid(word_valid),
      .word(word)
   );

   region_memory u_region_memory (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .load_mode(load_mode),
      .word_valid(word_valid),
      .word(word),
      .rd_index(rd_index),
      .rd_data(rd_data),
      .word_count(word_count)
   );

   dump_sequencer u_dump_sequencer (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .dump_en(dump_en),
      .busy(tx_busy),
      .rd_data(rd_data),
      .rd_index(rd_index),
      .tx_start(tx_start),
      .tx_byte(tx_byte),
      .dump_done(dump_done)
   );

   uart_tx u_uart_tx (
      .clk_100mhz(clk_100mhz),
      .sys_rst(sys_rst),
      .tx_start(tx_start),
      .tx_byte(tx_byte),
      .busy(tx_busy),
      .txd(uart_txd)
   );

endmodule

`default_nettype wire

// File: verilog/region_memory.sv
`timescale 1ns/1ns
`default_nettype none

module region_memory
   import lwe_mem_pkg::*;
(
   input wire clk_100mhz,
   input wire sys_rst,
   input wire load_mode,
   input wire word_valid,
   input wire [WORD_BITS-1:0] word,
   input wire [INDEX_BITS-1:0] rd_index,
   output logic [WORD_BITS-1:0] rd_data,
   output logic [INDEX_BITS-1:0] word_count
);

   logic [WORD_BITS-1:0] a_ram [A_DEPTH];
   logic [NARROW_BITS-1:0] pt_ram [PT_DEPTH];
   logic [NARROW_BITS-1:0] sk_ram [SK_DEPTH];
   logic [WORD_BITS-1:0] b_ram [B_DEPTH];

   logic wr_en;
   logic [1:0] wr_region;
   logic [1:0] rd_region;
   logic [1:0] rd_region_q; // lines up with the ram outputs
   logic [INDEX_BITS-1:0] wr_pt_off;
   logic [INDEX_BITS-1:0] wr_sk_off;
   logic [INDEX_BITS-1:0] wr_b_off;
   logic [INDEX_BITS-1:0] rd_pt_off;
   logic [INDEX_BITS-1:0] rd_sk_off;
   logic [INDEX_BITS-1:0] rd_b_off;
   logic [WORD_BITS-1:0] a_q;
   logic [WORD_BITS-1:0] b_q;
   logic [NARROW_BITS-1:0] pt_q;
   logic [NARROW_BITS-1:0] sk_q;

   function automatic logic [1:0] region_of(input logic [INDEX_BITS-1:0] idx);
      if (idx < INDEX_BITS'(PT_BASE)) begin
         return REGION_A;
      end else if (idx < INDEX_BITS'(SK_BASE)) begin
         return REGION_PT;
      end else if (idx < INDEX_BITS'(B_BASE)) begin
         return REGION_SK;
      end
      return REGION_B;
   endfunction

   assign wr_en = load_mode && word_valid && word_count < INDEX_BITS'(TOTAL_WORDS);
   assign wr_region = region_of(word_count);
   assign rd_region = region_of(rd_index);

   // local offsets, only the low bits are used per region
   assign wr_pt_off = word_count - INDEX_BITS'(PT_BASE);
   assign wr_sk_off = word_count - INDEX_BITS'(SK_BASE);
   assign wr_b_off = word_count - INDEX_BITS'(B_BASE);
   assign rd_pt_off = rd_index - INDEX_BITS'(PT_BASE);
   assign rd_sk_off = rd_index - INDEX_BITS'(SK_BASE);
   assign rd_b_off = rd_index - INDEX_BITS'(B_BASE);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         word_count <= '0;
      end else if (wr_en) begin
         word_count <= word_count + 1'b1;
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (wr_en) begin
         case (wr_region)
            REGION_A: a_ram[word_count[A_ADDR_BITS-1:0]] <= word;
            REGION_PT: pt_ram[wr_pt_off[PT_ADDR_BITS-1:0]] <= word[NARROW_BITS-1:0];
            REGION_SK: sk_ram[wr_sk_off[SK_ADDR_BITS-1:0]] <= word[NARROW_BITS-1:0];
            REGION_B: b_ram[wr_b_off[B_ADDR_BITS-1:0]] <= word;
         endcase
      end
   end

   // stage 1 ram read, stage 2 region mux
   always_ff @(posedge clk_100mhz) begin
      a_q <= a_ram[rd_index[A_ADDR_BITS-1:0]];
      pt_q <= pt_ram[rd_pt_off[PT_ADDR_BITS-1:0]];
      sk_q <= sk_ram[rd_sk_off[SK_ADDR_BITS-1:0]];
      b_q <= b_ram[rd_b_off[B_ADDR_BITS-1:0]];
      rd_region_q <= rd_region;
      case (rd_region_q)
         REGION_A: rd_data <= a_q;
         REGION_PT: rd_data <= {4{{(8 - NARROW_BITS){1'b0}}, pt_q}}; // same byte 4x
         REGION_SK: rd_data <= {4{{(8 - NARROW_BITS){1'b0}}, sk_q}};
         REGION_B: rd_data <= b_q;
      endcase
   end

   // extra frames after a full load must not move the count
   assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      word_count <= INDEX_BITS'(TOTAL_WORDS));

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
   import lwe_mem_pkg::*;
(
   input wire clk_100mhz,
   input wire sys_rst,
   input wire rxd,
   output logic rx_valid,
   output logic [7:0] rx_byte
);

   logic rxd_meta;
   logic rxd_sync;
   logic rxd_prev; // for falling edge detect
   logic active;
   logic [BAUD_CNT_BITS-1:0] clk_cnt;
   logic [3:0] bit_idx; // 0 start, 1..8 data, 9 stop
   logic sample_data;

   // middle of a data bit, one full period after the previous middle
   assign sample_data = active && bit_idx != 4'd0 && bit_idx != 4'd9
                        && clk_cnt == BAUD_CNT_BITS'(CLKS_PER_BIT - 1);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
         active <= 1'b0;
         clk_cnt <= '0;
         bit_idx <= '0;
         rx_valid <= 1'b0;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
         rx_valid <= 1'b0;
         if (!active) begin
            if (rxd_prev && !rxd_sync) begin
               active <= 1'b1;
               clk_cnt <= '0;
               bit_idx <= '0;
            end
         end else if (bit_idx == 4'd0) begin
            // half a period in, recheck the start bit
            if (clk_cnt == BAUD_CNT_BITS'(CLKS_PER_BIT / 2 - 1)) begin
               clk_cnt <= '0;
               if (rxd_sync) begin
                  active <= 1'b0; // glitch
               end else begin
                  bit_idx <= 4'd1;
               end
            end else begin
               clk_cnt <= clk_cnt + 1'b1;
            end
         end else if (clk_cnt == BAUD_CNT_BITS'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
               active <= 1'b0;
               rx_valid <= rxd_sync; // bad stop bit drops the frame
            end else begin
               bit_idx <= bit_idx + 1'b1;
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   // lsb first, so shift in from the top
   always_ff @(posedge clk_100mhz) begin
      if (sample_data) begin
         rx_byte <= {rxd_sync, rx_byte[7:1]};
      end
   end

   // downstream packer counts every strobe as a byte
   assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
   import lwe_mem_pkg::*;
(
   input wire clk_100mhz,
   input wire sys_rst,
   input wire tx_start,
   input wire [7:0] tx_byte,
   output logic busy,
   output logic txd
);

   logic [BAUD_CNT_BITS-1:0] clk_cnt;
   logic [3:0] bit_idx; // bit currently on the line
   logic [8:0] frame; // stop bit above the data
   logic bit_end;

   assign bit_end = busy && clk_cnt == BAUD_CNT_BITS'(CLKS_PER_BIT - 1);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         busy <= 1'b0;
         txd <= 1'b1; // idle line
         clk_cnt <= '0;
         bit_idx <= '0;
      end else if (!busy) begin
         if (tx_start) begin
            busy <= 1'b1;
            txd <= 1'b0; // start bit
            clk_cnt <= '0;
            bit_idx <= '0;
         end
      end else if (bit_end) begin
         clk_cnt <= '0;
         if (bit_idx == 4'd9) begin
            busy <= 1'b0; // stop bit done, line stays high
         end else begin
            txd <= frame[0];
            bit_idx <= bit_idx + 1'b1;
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_100mhz) begin
      if (tx_start && !busy) begin
         frame <= {1'b1, tx_byte};
      end else if (bit_end && bit_idx != 4'd9) begin
         frame <= {1'b1, frame[8:1]};
      end
   end

   // the dump sequencer must wait out the whole frame
   assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      tx_start |-> !busy);

endmodule

`default_nettype wire
